/* hw/io_consts.svh */
`ifndef IO_CONSTS_SVH
`define IO_CONSTS_SVH

// IO region in the address top nibble
`define IO_REGION_LSB     28    // Low bit of the region nibble
`define IO_REGION         4'h4  // 0x4xxxxxxx is IO

// One-hot register select bits
`define IO_SEL_PORT_IN    4     // GPIO input (read only)
`define IO_SEL_PORT_OUT   5     // GPIO output value
`define IO_SEL_PORT_DIR   6     // GPIO direction mask
// Bit 7 left free
`define IO_SEL_LEDS       8     // Direct LED bits
`define IO_SEL_SDM_RED    9     // Red brightness
`define IO_SEL_SDM_GREEN  10    // Green brightness
`define IO_SEL_SDM_BLUE   11    // Blue brightness
`define IO_SEL_TICKS      18    // Timer count
`define IO_SEL_RELOAD     19    // Timer reload value

// Write, clear, set, toggle at +0, +4, +8, +12
`define IO_OP_LSB         2

`endif

/* hw/io_pkg.sv */
package io_pkg;

   typedef logic [31:0] io_word_t;    // Bus address or data word
   typedef logic [7:0]  gpio_t;       // GPIO port width
   typedef logic [3:0]  led_mask_t;   // [0] red [1] green [2] blue [3] spare
   typedef logic [15:0] sdm_level_t;  // Modulator brightness

   typedef enum logic [1:0] {
      op_write  = 2'b00,  // Plain store
      op_clear  = 2'b01,  // Old AND NOT data
      op_set    = 2'b10,  // Old OR data
      op_toggle = 2'b11   // Old XOR data
   } io_op_e;

   typedef struct packed {
      io_word_t address;
      io_word_t wdata;
      logic     wr;       // One-cycle write strobe
      logic     rd;       // One-cycle read strobe
   } io_bus_t;

   typedef struct packed {
      logic reload;
      logic ticks;
      logic sdm_blue;
      logic sdm_green;
      logic sdm_red;
      logic leds;
      logic port_dir;
      logic port_out;
      logic port_in;
   } io_sel_t;

   typedef struct packed {
      logic     wstrb;    // Write strobe inside IO region
      logic     rstrb;    // Read strobe inside IO region
      io_sel_t  sel;
      io_op_e   op;
      io_word_t wdata;
   } io_cmd_t;

endpackage

/* hw/io_decode.sv */
`timescale 1ns/1ps

`include "io_consts.svh"

module io_decode (
   input  io_pkg::io_bus_t bus,
   output io_pkg::io_cmd_t cmd
);
   import io_pkg::*;

   logic is_io;  // Address top nibble hits the IO region

   // Only place that tests the region nibble
   assign is_io = (bus.address[`IO_REGION_LSB +: 4] == `IO_REGION);

   always_comb begin
      cmd.wstrb = bus.wr & is_io;
      cmd.rstrb = bus.rd & is_io;

      // One-hot selects copied straight from the address bits
      cmd.sel.port_in   = bus.address[`IO_SEL_PORT_IN];
      cmd.sel.port_out  = bus.address[`IO_SEL_PORT_OUT];
      cmd.sel.port_dir  = bus.address[`IO_SEL_PORT_DIR];
      cmd.sel.leds      = bus.address[`IO_SEL_LEDS];
      cmd.sel.sdm_red   = bus.address[`IO_SEL_SDM_RED];
      cmd.sel.sdm_green = bus.address[`IO_SEL_SDM_GREEN];
      cmd.sel.sdm_blue  = bus.address[`IO_SEL_SDM_BLUE];
      cmd.sel.ticks     = bus.address[`IO_SEL_TICKS];
      cmd.sel.reload    = bus.address[`IO_SEL_RELOAD];

      // Write operation from bits 3:2
      cmd.op    = io_op_e'(bus.address[`IO_OP_LSB +: 2]);
      cmd.wdata = bus.wdata;  // Word writes only
   end

endmodule

/* hw/io_registers.sv */
`timescale 1ns/1ps

module io_registers (
   input  logic               clk,
   input  logic               reset_button,
   input  io_pkg::io_cmd_t    cmd,
   input  io_pkg::io_word_t   io_rdata,   // Current value of the selected register(s)
   output io_pkg::gpio_t      port_out,
   output io_pkg::gpio_t      port_dir,
   output io_pkg::led_mask_t  leds,
   output io_pkg::sdm_level_t sdm_red,
   output io_pkg::sdm_level_t sdm_green,
   output io_pkg::sdm_level_t sdm_blue
);
   import io_pkg::*;

   io_word_t io_mod;  // Word to be stored after the operation

   // Read-modify-write in one cycle with the old value from the read mux
   always_comb begin
      case (cmd.op)
         op_clear:  io_mod = io_rdata & ~cmd.wdata;
         op_set:    io_mod = io_rdata |  cmd.wdata;
         op_toggle: io_mod = io_rdata ^  cmd.wdata;
         default:   io_mod = cmd.wdata;           // Plain write
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset_button) begin
         port_out  <= '0;
         port_dir  <= '0;                          // All pins inputs
         leds      <= '0;
         sdm_red   <= '0;
         sdm_green <= '0;
         sdm_blue  <= '0;
      end else if (cmd.wstrb) begin
         // Every selected register takes the same word
         if (cmd.sel.port_out)
            port_out <= gpio_t'(io_mod);
         if (cmd.sel.port_dir)
            port_dir <= gpio_t'(io_mod);
         if (cmd.sel.leds)
            leds <= led_mask_t'(io_mod);
         if (cmd.sel.sdm_red)
            sdm_red <= sdm_level_t'(io_mod);
         if (cmd.sel.sdm_green)
            sdm_green <= sdm_level_t'(io_mod);
         if (cmd.sel.sdm_blue)
            sdm_blue <= sdm_level_t'(io_mod);
         // Ticks and reload are handled by the timer
      end
   end

endmodule

/* hw/io_timer.sv */
`timescale 1ns/1ps

module io_timer (
   input  logic             clk,
   input  logic             reset_button,
   input  io_pkg::io_cmd_t  cmd,
   output io_pkg::io_word_t ticks,
   output io_pkg::io_word_t reload,
   output logic             interrupt     // One cycle after the wrap
);
   import io_pkg::*;

   logic [32:0] ticks_plus_1;  // Carry bit flags the overflow
   io_word_t    next_ticks;

   assign ticks_plus_1 = {1'b0, ticks} + 33'd1;

   // On overflow restart from reload instead of zero
   assign next_ticks = ticks_plus_1[32] ? reload : ticks_plus_1[31:0];

   always_ff @(posedge clk) begin
      if (reset_button) begin
         ticks     <= '0;
         reload    <= '0;
         interrupt <= 1'b0;
      end else begin
         // Timer writes store plain data and ignore op
         if (cmd.wstrb && cmd.sel.ticks)
            ticks <= cmd.wdata;                   // Write wins over counting
         else
            ticks <= next_ticks;

         if (cmd.wstrb && cmd.sel.reload)
            reload <= cmd.wdata;

         interrupt <= ticks_plus_1[32];           // Pulse on overflow
      end
   end

endmodule

/* hw/led_sdm.sv */
`timescale 1ns/1ps

module led_sdm (
   input  logic               clk,
   input  logic               reset_button,
   input  io_pkg::led_mask_t  leds,
   input  io_pkg::sdm_level_t sdm_red,
   input  io_pkg::sdm_level_t sdm_green,
   input  io_pkg::sdm_level_t sdm_blue,
   output logic               led_red,
   output logic               led_green,
   output logic               led_blue
);
   import io_pkg::*;

   sdm_level_t level [3];   // 0 red, 1 green, 2 blue
   sdm_level_t phase [3];   // Phase accumulators
   logic [2:0] sdm_out;     // Registered carry out per channel

   assign level[0] = sdm_red;
   assign level[1] = sdm_green;
   assign level[2] = sdm_blue;

   // First order modulator with a carry rate of level / 65536
   always_ff @(posedge clk) begin
      for (int i = 0; i < 3; i++) begin
         if (reset_button)
            {sdm_out[i], phase[i]} <= '0;
         else
            {sdm_out[i], phase[i]} <= {1'b0, phase[i]} + {1'b0, level[i]};
      end
   end

   // Direct bit forces the LED fully on
   assign led_red   = leds[0] | sdm_out[0];
   assign led_green = leds[1] | sdm_out[1];
   assign led_blue  = leds[2] | sdm_out[2];  // leds[3] only stored

endmodule

/* hw/io_readback.sv */
`timescale 1ns/1ps

module io_readback (
   input  logic               clk,
   input  logic               reset_button,
   input  io_pkg::io_cmd_t    cmd,
   input  io_pkg::gpio_t      port_in,
   input  io_pkg::gpio_t      port_out,
   input  io_pkg::gpio_t      port_dir,
   input  io_pkg::led_mask_t  leds,
   input  io_pkg::sdm_level_t sdm_red,
   input  io_pkg::sdm_level_t sdm_green,
   input  io_pkg::sdm_level_t sdm_blue,
   input  io_pkg::io_word_t   ticks,
   input  io_pkg::io_word_t   reload,
   output io_pkg::io_word_t   io_rdata,   // Combinational value that also feeds read-modify-write
   output io_pkg::io_word_t   rdata       // Held until the next IO read
);
   import io_pkg::*;

   // One-hot OR mux where several selects merge their values
   assign io_rdata =
      (cmd.sel.port_in   ? io_word_t'(port_in)   : '0) |  // GPIO in
      (cmd.sel.port_out  ? io_word_t'(port_out)  : '0) |  // GPIO out
      (cmd.sel.port_dir  ? io_word_t'(port_dir)  : '0) |  // GPIO dir
      (cmd.sel.leds      ? io_word_t'(leds)      : '0) |  // Direct LEDs
      (cmd.sel.sdm_red   ? io_word_t'(sdm_red)   : '0) |
      (cmd.sel.sdm_green ? io_word_t'(sdm_green) : '0) |
      (cmd.sel.sdm_blue  ? io_word_t'(sdm_blue)  : '0) |
      (cmd.sel.ticks     ? ticks                 : '0) |  // Live count
      (cmd.sel.reload    ? reload                : '0);

   // Capture in the strobe cycle so side effects see the right value
   always_ff @(posedge clk) begin
      if (reset_button)
         rdata <= '0;
      else if (cmd.rstrb)
         rdata <= io_rdata;
   end

endmodule

/* hw/io_peripherals.sv */
`timescale 1ns/1ps

module io_peripherals (
   input  logic             clk,
   input  logic             reset_button,
   input  io_pkg::io_bus_t  bus,
   input  io_pkg::gpio_t    port_in,
   output io_pkg::io_word_t rdata,
   output io_pkg::gpio_t    port_out,
   output io_pkg::gpio_t    port_dir,
   output logic             led_red,
   output logic             led_green,
   output logic             led_blue,
   output logic             interrupt
);
   import io_pkg::*;

   io_cmd_t    cmd;          // Decoded IO request
   io_word_t   io_rdata;     // Unregistered read value
   led_mask_t  leds;
   sdm_level_t sdm_red;
   sdm_level_t sdm_green;
   sdm_level_t sdm_blue;
   io_word_t   ticks;
   io_word_t   reload;

   // Memory map and strobes
   io_decode u_io_decode (
      .bus (bus),
      .cmd (cmd)
   );

   // Write, clear, set, toggle on GPIO and LED registers
   io_registers u_io_registers (
      .clk          (clk),
      .reset_button (reset_button),
      .cmd          (cmd),
      .io_rdata     (io_rdata),
      .port_out     (port_out),
      .port_dir     (port_dir),
      .leds         (leds),
      .sdm_red      (sdm_red),
      .sdm_green    (sdm_green),
      .sdm_blue     (sdm_blue)
   );

   io_timer u_io_timer (
      .clk          (clk),
      .reset_button (reset_button),
      .cmd          (cmd),
      .ticks        (ticks),
      .reload       (reload),
      .interrupt    (interrupt)
   );

   led_sdm u_led_sdm (
      .clk          (clk),
      .reset_button (reset_button),
      .leds         (leds),
      .sdm_red      (sdm_red),
      .sdm_green    (sdm_green),
      .sdm_blue     (sdm_blue),
      .led_red      (led_red),
      .led_green    (led_green),
      .led_blue     (led_blue)
   );

   // Read mux that also feeds the old value back for read-modify-write
   io_readback u_io_readback (
      .clk          (clk),
      .reset_button (reset_button),
      .cmd          (cmd),
      .port_in      (port_in),
      .port_out     (port_out),
      .port_dir     (port_dir),
      .leds         (leds),
      .sdm_red      (sdm_red),
      .sdm_green    (sdm_green),
      .sdm_blue     (sdm_blue),
      .ticks        (ticks),
      .reload       (reload),
      .io_rdata     (io_rdata),
      .rdata        (rdata)
   );

endmodule

/* tests/tb_io_checks.svh */
`ifndef TB_IO_CHECKS_SVH
`define TB_IO_CHECKS_SVH

// Reference state for the GPIO registers
gpio_t model_port_out = '0;
gpio_t model_port_dir = '0;
int    error_count    = 0;    // Failed checks over the whole run

// New register value from the operation rules
function automatic gpio_t apply_op(gpio_t old, gpio_t data, io_op_e op);
   case (op)
      op_write:  return data;
      op_clear:  return old & ~data;   // Clear the bits given in data
      op_set:    return old | data;
      default:   return old ^ data;    // Toggle
   endcase
endfunction

// Compare a DUT value with its expected value
task automatic check_value(string name, io_word_t expected, io_word_t actual);
   assert (actual == expected)
   else begin
      $display("Mismatch at time %0t: %s expected 0x%08h, actual 0x%08h",
               $time, name, expected, actual);
      error_count++;
   end
endtask

// Condition that has no single expected value
task automatic check_true(logic cond, string what);
   assert (cond)
   else begin
      $display("Error at time %0t: %s", $time, what);
      error_count++;
   end
endtask

`endif

/* tests/tb_io_peripherals.sv */
`timescale 1ns/1ps

`include "io_consts.svh"

module tb_io_peripherals;
   import io_pkg::*;

   `include "tb_io_checks.svh"

   localparam int CLK_PERIOD   = 20;
   localparam int N_OPS        = 24;                  // Random GPIO operations
   localparam io_word_t RELOAD = 32'hffff_fff0;      // All-ones minus 15
   // Cycle budget per test plus a margin
   localparam int RUN_CYCLES   = 10 + N_OPS * 8 + 20 + 60 + 1024 + 40;
   localparam int WATCHDOG_NS  = (RUN_CYCLES + 300) * CLK_PERIOD;

   logic     clk;
   logic     reset_button;
   io_bus_t  bus;
   gpio_t    port_in;
   io_word_t rdata;
   gpio_t    port_out;
   gpio_t    port_dir;
   logic     led_red;
   logic     led_green;
   logic     led_blue;
   logic     interrupt;

   io_word_t lfsr_state = 32'h2a0d;
   int       tests_run = 0;
   int       tests_failed = 0;
   int       errors_at_start = 0;

   io_peripherals u_io_peripherals (
      .clk          (clk),
      .reset_button (reset_button),
      .bus          (bus),
      .port_in      (port_in),
      .rdata        (rdata),
      .port_out     (port_out),
      .port_dir     (port_dir),
      .led_red      (led_red),
      .led_green    (led_green),
      .led_blue     (led_blue),
      .interrupt    (interrupt)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Taps 32, 22, 2, 1; the new bit enters at bit 0
   function automatic io_word_t rand_bits(int n);
      io_word_t r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = {lfsr_state[30:0],
                       lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
         r = {r[30:0], lfsr_state[0]};        // One step per bit taken
      end
      return r;
   endfunction

   function automatic io_word_t io_addr(int sel_bit, io_op_e op);
      return (io_word_t'(`IO_REGION) << `IO_REGION_LSB) | (io_word_t'(1) << sel_bit) |
             (io_word_t'(op) << `IO_OP_LSB);
   endfunction

   task automatic bus_write(io_word_t addr, io_word_t data);
      @(posedge clk);
      #2;
      bus.address = addr;
      bus.wdata   = data;
      bus.wr      = 1'b1;
      @(posedge clk);                          // Write lands on this edge
      #2;
      bus.wr      = 1'b0;
   endtask

   task automatic bus_read(input io_word_t addr, output io_word_t value);
      @(posedge clk);
      #2;
      bus.address = addr;
      bus.rd      = 1'b1;
      @(posedge clk);
      #2;
      bus.rd      = 1'b0;
      value       = rdata;                     // Loaded at the strobe edge
   endtask

   task automatic read_check(io_word_t addr, string name, io_word_t expected);
      io_word_t value;
      bus_read(addr, value);
      check_value(name, expected, value);
   endtask

   task automatic end_test(string name);
      tests_run++;
      if (error_count == errors_at_start)
         $display("test %-14s ok", name);
      else begin
         tests_failed++;
         $display("test %-14s FAILED with %0d errors", name, error_count - errors_at_start);
      end
      errors_at_start = error_count;
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
      $display("tests failed");
      $finish;
   end

   initial begin
      io_op_e   op;
      io_word_t data;
      io_word_t pick;
      io_word_t value;
      int       high_count;

      reset_button = 1'b1;
      bus          = '0;
      port_in      = '0;
      repeat (4) @(posedge clk);
      #2;
      reset_button = 1'b0;

      check_value("port_out", '0, io_word_t'(port_out));
      check_value("port_dir", '0, io_word_t'(port_dir));
      check_value("led_rgb", '0, io_word_t'({led_red, led_green, led_blue}));
      check_value("interrupt", '0, io_word_t'(interrupt));
      check_value("rdata", '0, rdata);
      end_test("reset");

      for (int i = 0; i < N_OPS; i++) begin
         op   = io_op_e'(rand_bits(2));
         pick = rand_bits(1);
         data = rand_bits(32);                 // Upper bits must be dropped
         if (pick[0]) begin
            model_port_dir = apply_op(model_port_dir, gpio_t'(data), op);
            bus_write(io_addr(`IO_SEL_PORT_DIR, op), data);
         end else begin
            model_port_out = apply_op(model_port_out, gpio_t'(data), op);
            bus_write(io_addr(`IO_SEL_PORT_OUT, op), data);
         end
         check_value("port_out", io_word_t'(model_port_out), io_word_t'(port_out));
         check_value("port_dir", io_word_t'(model_port_dir), io_word_t'(port_dir));
         read_check(io_addr(`IO_SEL_PORT_OUT, op_write), "rdata port_out",
                    io_word_t'(model_port_out));
         read_check(io_addr(`IO_SEL_PORT_DIR, op_write), "rdata port_dir",
                    io_word_t'(model_port_dir));
      end
      end_test("write_ops");

      port_in = gpio_t'(rand_bits(8));
      read_check(io_addr(`IO_SEL_PORT_IN, op_write), "rdata port_in", io_word_t'(port_in));
      read_check({4'h4, 28'h0}, "rdata no select", '0);
      // Top nibble 5 selects a GPIO register but lies outside the IO region
      bus_write({4'h5, 28'h0} | (io_word_t'(1) << `IO_SEL_PORT_OUT),
                {24'h0, ~model_port_out});
      bus_write({4'h5, 28'h0} | (io_word_t'(1) << `IO_SEL_PORT_DIR),
                {24'h0, ~model_port_dir});
      check_value("port_out", io_word_t'(model_port_out), io_word_t'(port_out));
      check_value("port_dir", io_word_t'(model_port_dir), io_word_t'(port_dir));
      end_test("read_select");

      bus_write(io_addr(`IO_SEL_RELOAD, op_write), RELOAD);
      bus_write(io_addr(`IO_SEL_TICKS, op_write), RELOAD);
      // 16 counts from reload to the wrap and the pulse one cycle later
      for (int k = 1; k <= 48; k++) begin
         @(posedge clk);
         #2;
         check_value("interrupt", io_word_t'(k % 16 == 0), io_word_t'(interrupt));
      end
      bus_read(io_addr(`IO_SEL_TICKS, op_write), value);
      check_true(value >= RELOAD,
                 $sformatf("ticks read 0x%08h is below the reload value", value));
      end_test("timer");

      bus_write(io_addr(`IO_SEL_LEDS, op_write), '0);
      bus_write(io_addr(`IO_SEL_SDM_RED, op_write), 32'h4000);
      high_count = 0;
      repeat (1024) begin
         @(posedge clk);
         #2;
         if (led_red)
            high_count++;
      end
      check_value("led_red high cycles", 256, io_word_t'(high_count));  // Quarter duty
      bus_write(io_addr(`IO_SEL_LEDS, op_set), 32'h1);
      repeat (16) begin
         @(posedge clk);
         #2;
         check_value("led_red", 1, io_word_t'(led_red));
      end
      end_test("sigma_delta");

      $display("%0d tests run, %0d passed, %0d failed, %0d failed checks",
               tests_run, tests_run - tests_failed, tests_failed, error_count);
      if (error_count == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

/* io_peripherals.f */
+incdir+hw
+incdir+tests
hw/io_pkg.sv
hw/io_decode.sv
hw/io_registers.sv
hw/io_timer.sv
hw/led_sdm.sv
hw/io_readback.sv
hw/io_peripherals.sv
tests/tb_io_peripherals.sv

/* Makefile */
# Verilator build and run for the IO peripheral block

VERILATOR ?= verilator
TOP       ?= tb_io_peripherals
FILELIST  ?= io_peripherals.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= all tests passed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
SOURCES   := $(wildcard hw/*.sv hw/*.svh tests/*.sv tests/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
